// ==== arbiter/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import soc_bus_pkg::*; (
  input  wire     clk,
  input  wire     rst,
  // fetch read port
  input  rd_req_t ifu_rd_req_i,
  input  wire     ifu_rd_valid_i,
  output logic    ifu_rd_ready_o,
  output rd_rsp_t ifu_rd_rsp_o,
  output logic    ifu_rsp_valid_o,
  input  wire     ifu_rsp_ready_i,
  // load read port
  input  rd_req_t lsu_rd_req_i,
  input  wire     lsu_rd_valid_i,
  output logic    lsu_rd_ready_o,
  output rd_rsp_t lsu_rd_rsp_o,
  output logic    lsu_rsp_valid_o,
  input  wire     lsu_rsp_ready_i,
  // store port
  input  wr_req_t lsu_wr_req_i,
  input  wire     lsu_wr_valid_i,
  output logic    lsu_wr_ready_o,
  output wr_rsp_t lsu_wr_rsp_o,
  output logic    lsu_wr_rsp_valid_o,
  input  wire     lsu_wr_rsp_ready_i,
  // memory slave
  output rd_req_t mem_rd_req_o,
  output logic    mem_rd_valid_o,
  input  wire     mem_rd_ready_i,
  input  rd_rsp_t mem_rd_rsp_i,
  input  wire     mem_rd_rsp_valid_i,
  output logic    mem_rd_rsp_ready_o,
  output wr_req_t mem_wr_req_o,
  output logic    mem_wr_valid_o,
  input  wire     mem_wr_ready_i,
  input  wr_rsp_t mem_wr_rsp_i,
  input  wire     mem_wr_rsp_valid_i,
  output logic    mem_wr_rsp_ready_o,
  // timer slave, reads only
  output rd_req_t clint_rd_req_o,
  output logic    clint_rd_valid_o,
  input  wire     clint_rd_ready_i,
  input  rd_rsp_t clint_rd_rsp_i,
  input  wire     clint_rd_rsp_valid_i,
  output logic    clint_rd_rsp_ready_o,
  // serial slave, stores only
  output wr_req_t uart_wr_req_o,
  output logic    uart_wr_valid_o,
  input  wire     uart_wr_ready_i,
  input  wr_rsp_t uart_wr_rsp_i,
  input  wire     uart_wr_rsp_valid_i,
  output logic    uart_wr_rsp_ready_o
);

  typedef enum logic [1:0] {
    IDLE,
    IFU_BUSY,
    LSU_BUSY
  } rd_state_e;

  rd_state_e state_q;
  logic      last_lsu_q;
  logic      hold_q;
  logic      hold_lsu_q;
  logic      rd_clint_q;
  logic      wr_busy_q;
  logic      wr_uart_q;

  logic sel_ifu;
  logic sel_lsu;
  logic lsu_to_clint;
  logic wr_to_uart;

  // address decode
  assign lsu_to_clint = (lsu_rd_req_i.addr == RTC_ADDR_LO) ||
                        (lsu_rd_req_i.addr == RTC_ADDR_HI);
  assign wr_to_uart   = (lsu_wr_req_i.addr == SERIAL_ADDR);

  // read grant, kept on one master once presented so the slave sees a stable request
  always_comb begin
    sel_ifu = 1'b0;
    sel_lsu = 1'b0;
    if (state_q == IDLE) begin
      if (hold_q) begin
        sel_ifu = !hold_lsu_q;
        sel_lsu = hold_lsu_q;
      end else if (ifu_rd_valid_i && lsu_rd_valid_i) begin
        sel_ifu = last_lsu_q;
        sel_lsu = !last_lsu_q;
      end else begin
        sel_ifu = ifu_rd_valid_i;
        sel_lsu = lsu_rd_valid_i;
      end
    end
  end

  // read request toward the slaves
  assign mem_rd_req_o     = sel_lsu ? lsu_rd_req_i : ifu_rd_req_i;
  assign mem_rd_valid_o   = sel_ifu || (sel_lsu && !lsu_to_clint);
  assign clint_rd_req_o   = lsu_rd_req_i;
  assign clint_rd_valid_o = sel_lsu && lsu_to_clint;
  assign ifu_rd_ready_o   = sel_ifu && mem_rd_ready_i;
  assign lsu_rd_ready_o   = sel_lsu && (lsu_to_clint ? clint_rd_ready_i : mem_rd_ready_i);

  // read responses back to the granted master
  assign ifu_rd_rsp_o    = mem_rd_rsp_i;
  assign ifu_rsp_valid_o = (state_q == IFU_BUSY) && mem_rd_rsp_valid_i;
  assign lsu_rd_rsp_o    = rd_clint_q ? clint_rd_rsp_i : mem_rd_rsp_i;
  assign lsu_rsp_valid_o = (state_q == LSU_BUSY) &&
                           (rd_clint_q ? clint_rd_rsp_valid_i : mem_rd_rsp_valid_i);
  assign mem_rd_rsp_ready_o   = ((state_q == IFU_BUSY) && ifu_rsp_ready_i) ||
                                ((state_q == LSU_BUSY) && !rd_clint_q && lsu_rsp_ready_i);
  assign clint_rd_rsp_ready_o = (state_q == LSU_BUSY) && rd_clint_q && lsu_rsp_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= IDLE;
      last_lsu_q <= 1'b1;
      hold_q     <= 1'b0;
      hold_lsu_q <= 1'b0;
      rd_clint_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (ifu_rd_valid_i && ifu_rd_ready_o) begin
            state_q    <= IFU_BUSY;
            last_lsu_q <= 1'b0;
            hold_q     <= 1'b0;
          end else if (lsu_rd_valid_i && lsu_rd_ready_o) begin
            state_q    <= LSU_BUSY;
            last_lsu_q <= 1'b1;
            rd_clint_q <= lsu_to_clint;
            hold_q     <= 1'b0;
          end else if (sel_ifu || sel_lsu) begin
            hold_q     <= 1'b1;
            hold_lsu_q <= sel_lsu;
          end
        end
        IFU_BUSY: begin
          if (ifu_rsp_valid_o && ifu_rsp_ready_i) begin
            state_q <= IDLE;
          end
        end
        LSU_BUSY: begin
          if (lsu_rsp_valid_o && lsu_rsp_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // store path, one store outstanding at a time
  assign mem_wr_req_o    = lsu_wr_req_i;
  assign uart_wr_req_o   = lsu_wr_req_i;
  assign mem_wr_valid_o  = !wr_busy_q && lsu_wr_valid_i && !wr_to_uart;
  assign uart_wr_valid_o = !wr_busy_q && lsu_wr_valid_i && wr_to_uart;
  assign lsu_wr_ready_o  = !wr_busy_q && (wr_to_uart ? uart_wr_ready_i : mem_wr_ready_i);

  assign lsu_wr_rsp_o        = wr_uart_q ? uart_wr_rsp_i : mem_wr_rsp_i;
  assign lsu_wr_rsp_valid_o  = wr_busy_q && (wr_uart_q ? uart_wr_rsp_valid_i : mem_wr_rsp_valid_i);
  assign mem_wr_rsp_ready_o  = wr_busy_q && !wr_uart_q && lsu_wr_rsp_ready_i;
  assign uart_wr_rsp_ready_o = wr_busy_q && wr_uart_q && lsu_wr_rsp_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_busy_q <= 1'b0;
      wr_uart_q <= 1'b0;
    end else if (lsu_wr_valid_i && lsu_wr_ready_o) begin
      wr_busy_q <= 1'b1;
      wr_uart_q <= wr_to_uart;
    end else if (lsu_wr_rsp_valid_o && lsu_wr_rsp_ready_i) begin
      wr_busy_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== clint/clint_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint_timer import soc_bus_pkg::*; (
  input  wire     clk,
  input  wire     rst,
  input  rd_req_t rd_req_i,
  input  wire     rd_valid_i,
  output logic    rd_ready_o,
  output rd_rsp_t rd_rsp_o,
  output logic    rd_rsp_valid_o,
  input  wire     rd_rsp_ready_i
);

  mtime_t mtime_q;
  data_t  rsp_data_q;
  logic   rsp_valid_q;

  // free running machine time
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // one read in flight, next accepted after the response is taken
  assign rd_ready_o = !rsp_valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid_q <= 1'b0;
    end else if (rd_valid_i && rd_ready_o) begin
      rsp_valid_q <= 1'b1;
    end else if (rd_rsp_valid_o && rd_rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // addr bit 2 picks the high word
  always_ff @(posedge clk) begin
    if (rd_valid_i && rd_ready_o) begin
      rsp_data_q <= rd_req_i.addr[2] ? mtime_q[63:32] : mtime_q[31:0];
    end
  end

  assign rd_rsp_o.data  = rsp_data_q;
  assign rd_rsp_o.resp  = OKAY;
  assign rd_rsp_valid_o = rsp_valid_q;

endmodule

`default_nettype wire

// ==== common/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

  // basic bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [7:0]  byte_t;
  typedef logic [63:0] mtime_t;

  // same encoding as AXI xRESP
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_t;

  // read address channel
  typedef struct packed {
    addr_t addr;
  } rd_req_t;

  // read data channel
  typedef struct packed {
    data_t data;
    resp_t resp;
  } rd_rsp_t;

  // store request, address and data in one beat
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } wr_req_t;

  // store response
  typedef struct packed {
    resp_t resp;
  } wr_rsp_t;

  // address map
  localparam addr_t SERIAL_ADDR = 32'h1000_0000;
  localparam addr_t RTC_ADDR_LO = 32'h0200_bff8;
  localparam addr_t RTC_ADDR_HI = 32'h0200_bffc;

  // on-chip memory, word index from addr[9:2]
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW    = $clog2(MEM_WORDS);
  typedef logic [MEM_AW-1:0] mem_idx_t;

  // ready throttle LFSR
  localparam int LFSR_W = 20;
  typedef logic [LFSR_W-1:0] lfsr_t;

  // serial port pace and queue
  localparam int UART_DIV   = 16;
  localparam int UART_DEPTH = 4;
  localparam int UART_DIV_W = $clog2(UART_DIV);
  localparam int UART_PTR_W = $clog2(UART_DEPTH);
  localparam int UART_CNT_W = $clog2(UART_DEPTH + 1);
  typedef logic [UART_DIV_W-1:0] uart_div_t;
  typedef logic [UART_PTR_W-1:0] uart_ptr_t;
  typedef logic [UART_CNT_W-1:0] uart_cnt_t;

endpackage

`default_nettype wire

// ==== sources.f ====
+incdir+verification
common/soc_bus_pkg.sv
arbiter/bus_arbiter.sv
clint/clint_timer.sv
uart/uart_tx_queue.sv
verilog/sram_slave.sv
verilog/soc_bus_top.sv
verification/soc_bus_tb.sv

// ==== uart/uart_tx_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx_queue import soc_bus_pkg::*; (
  input  wire     clk,
  input  wire     rst,
  input  wr_req_t wr_req_i,
  input  wire     wr_valid_i,
  output logic    wr_ready_o,
  output wr_rsp_t wr_rsp_o,
  output logic    wr_rsp_valid_o,
  input  wire     wr_rsp_ready_i,
  output byte_t   char_o,
  output logic    char_valid_o
);

  byte_t     fifo_q [UART_DEPTH];
  uart_ptr_t wr_ptr_q;
  uart_ptr_t rd_ptr_q;
  uart_cnt_t count_q;
  uart_div_t div_q;
  logic      rsp_valid_q;
  byte_t     char_q;
  logic      char_valid_q;

  logic push;
  logic pop;
  logic tick;

  assign wr_ready_o = !rsp_valid_q && (count_q != uart_cnt_t'(UART_DEPTH));
  assign push       = wr_valid_i && wr_ready_o;
  assign tick       = (div_q == uart_div_t'(UART_DIV - 1));
  assign pop        = tick && (count_q != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      div_q        <= '0;
      rsp_valid_q  <= 1'b0;
      char_valid_q <= 1'b0;
    end else begin
      div_q        <= tick ? '0 : div_q + 1'b1;
      char_valid_q <= pop;
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
      // write response follows the accepted store by one cycle
      if (push) begin
        rsp_valid_q <= 1'b1;
      end else if (wr_rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  // only the low byte of the store is sent
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= wr_req_i.data[7:0];
    end
    if (pop) begin
      char_q <= fifo_q[rd_ptr_q];
    end
  end

  assign wr_rsp_o.resp  = OKAY;
  assign wr_rsp_valid_o = rsp_valid_q;
  assign char_o         = char_q;
  assign char_valid_o   = char_valid_q;

endmodule

`default_nettype wire

// ==== verification/soc_bus_model.svh ====
`ifndef SOC_BUS_MODEL_SVH
`define SOC_BUS_MODEL_SVH

// expected memory contents, word index from addr[9:2]
data_t model_mem [MEM_WORDS];

// serial bytes accepted but not yet seen on the output, oldest first
byte_t serial_q [$];

// timer low word history
data_t last_lo;
bit    lo_seen;

function automatic void model_clear();
  for (int i = 0; i < MEM_WORDS; i++) begin
    model_mem[i] = '0;
  end
  serial_q.delete();
  last_lo = '0;
  lo_seen = 1'b0;
endfunction

// only loads decode to the timer, fetches of these words hit memory
function automatic bit hits_timer(input addr_t a);
  return (a == RTC_ADDR_LO) || (a == RTC_ADDR_HI);
endfunction

function automatic data_t model_word(input addr_t a);
  return model_mem[a[9:2]];
endfunction

// applied when the store address transfer completes
function automatic void model_store(input wr_req_t req);
  if (req.addr == SERIAL_ADDR) begin
    serial_q.push_back(req.data[7:0]);
  end else begin
    for (int b = 0; b < 4; b++) begin
      if (req.strb[b]) begin
        model_mem[req.addr[9:2]][8*b +: 8] = req.data[8*b +: 8];
      end
    end
  end
endfunction

// mtime only counts up and cannot run ahead of the cycles since reset
function automatic bit timer_lo_ok(input data_t v, input int unsigned cycles_now);
  bit ok;
  ok = (v <= cycles_now) && (!lo_seen || v > last_lo);
  last_lo = v;
  lo_seen = 1'b1;
  return ok;
endfunction

`endif

// ==== verification/soc_bus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_tb import soc_bus_pkg::*; ();

  localparam int N_FETCH    = 120;
  localparam int N_LOAD     = 120;
  localparam int N_STORE    = 120;
  localparam int MAX_CYCLES = 40 * (N_FETCH + N_LOAD + N_STORE);

  logic    clk = 1'b0;
  logic    rst;
  rd_req_t ifu_req;
  logic    ifu_valid;
  logic    ifu_ready;
  rd_rsp_t ifu_rsp;
  logic    ifu_rsp_valid;
  logic    ifu_rsp_rdy;
  rd_req_t lsu_req;
  logic    lsu_valid;
  logic    lsu_ready;
  rd_rsp_t lsu_rsp;
  logic    lsu_rsp_valid;
  logic    lsu_rsp_rdy;
  wr_req_t st_req;
  logic    st_valid;
  logic    st_ready;
  wr_rsp_t st_rsp;
  logic    st_rsp_valid;
  logic    st_rsp_rdy;
  byte_t   uart_char;
  logic    uart_char_valid;

  // per master bookkeeping
  int          ifu_sent, ifu_done, lsu_sent, lsu_done, st_sent, st_done;
  bit          ifu_wait, lsu_wait, st_wait;
  data_t       ifu_exp, lsu_exp;
  int          lsu_kind;
  int          ifu_runs, lsu_runs;
  int unsigned cycles;
  logic [31:0] rng_state;
  int          checks [5];
  int          errs [5];
  string       test_name [5] = '{"memory reads", "serial bytes", "timer reads",
                                 "read fairness", "handshakes"};

  `include "soc_bus_model.svh"

  soc_bus_top u_dut (
    .clk                (clk),
    .rst                (rst),
    .ifu_rd_req_i       (ifu_req),
    .ifu_rd_valid_i     (ifu_valid),
    .ifu_rd_ready_o     (ifu_ready),
    .ifu_rd_rsp_o       (ifu_rsp),
    .ifu_rsp_valid_o    (ifu_rsp_valid),
    .ifu_rsp_ready_i    (ifu_rsp_rdy),
    .lsu_rd_req_i       (lsu_req),
    .lsu_rd_valid_i     (lsu_valid),
    .lsu_rd_ready_o     (lsu_ready),
    .lsu_rd_rsp_o       (lsu_rsp),
    .lsu_rsp_valid_o    (lsu_rsp_valid),
    .lsu_rsp_ready_i    (lsu_rsp_rdy),
    .lsu_wr_req_i       (st_req),
    .lsu_wr_valid_i     (st_valid),
    .lsu_wr_ready_o     (st_ready),
    .lsu_wr_rsp_o       (st_rsp),
    .lsu_wr_rsp_valid_o (st_rsp_valid),
    .lsu_wr_rsp_ready_i (st_rsp_rdy),
    .uart_char_o        (uart_char),
    .uart_char_valid_o  (uart_char_valid)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // 16 memory words or one of the two timer words
  function automatic addr_t pick_read_addr(input logic [23:0] n);
    int m;
    m = n % 18;
    if (m < 16) begin
      return addr_t'(m * 4);
    end
    return (m == 16) ? RTC_ADDR_LO : RTC_ADDR_HI;
  endfunction

  function automatic bit all_done();
    return (ifu_done == N_FETCH) && (lsu_done == N_LOAD) && (st_done == N_STORE) &&
           (serial_q.size() == 0);
  endfunction

  task automatic check_value(input int id, input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks[id]++;
    if (got !== exp) begin
      errs[id]++;
      $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  always @(posedge clk) begin
    logic [31:0] r;
    addr_t       a;
    if (!rst) begin
      cycles++;
      // a held read keeps the other master out
      if (ifu_wait) begin
        check_value(4, lsu_ready, 0, "load ready while a fetch is held");
      end
      if (lsu_wait) begin
        check_value(4, ifu_ready, 0, "fetch ready while a load is held");
      end

      if (ifu_rsp_valid && ifu_rsp_rdy) begin
        if (!ifu_wait) begin
          $display("fetch response at %0t ns without an open request", $time);
          errs[4]++;
        end else begin
          check_value(0, ifu_rsp.data, ifu_exp, "fetch data");
          check_value(4, ifu_rsp.resp, OKAY, "fetch response code");
          ifu_wait = 1'b0;
          ifu_done++;
          if (lsu_valid) begin
            ifu_runs++;
            check_value(3, ifu_runs <= 1, 1, "fetch served twice while a load waits");
          end
        end
      end

      if (lsu_rsp_valid && lsu_rsp_rdy) begin
        if (!lsu_wait) begin
          $display("load response at %0t ns without an open request", $time);
          errs[4]++;
        end else begin
          if (lsu_kind == 0) begin
            check_value(0, lsu_rsp.data, lsu_exp, "load data");
          end else if (lsu_kind == 1) begin
            check_value(2, timer_lo_ok(lsu_rsp.data, cycles), 1, "timer low word");
          end else begin
            check_value(2, lsu_rsp.data, 0, "timer high word");
          end
          check_value(4, lsu_rsp.resp, OKAY, "load response code");
          lsu_wait = 1'b0;
          lsu_done++;
          if (ifu_valid) begin
            lsu_runs++;
            check_value(3, lsu_runs <= 1, 1, "load served twice while a fetch waits");
          end
        end
      end

      if (st_rsp_valid && st_rsp_rdy) begin
        if (!st_wait) begin
          $display("store response at %0t ns without an open store", $time);
          errs[4]++;
        end else begin
          check_value(4, st_rsp.resp, OKAY, "store response code");
          st_wait = 1'b0;
          st_done++;
        end
      end

      if (uart_char_valid) begin
        if (serial_q.size() == 0) begin
          $display("serial byte %h at %0t ns with no store behind it", uart_char, $time);
          errs[1]++;
        end else begin
          check_value(1, uart_char, serial_q.pop_front(), "serial byte");
        end
      end

      // read expectations use the image from before this edge's store
      if (ifu_valid && ifu_ready) begin
        ifu_exp  = model_word(ifu_req.addr);
        ifu_wait = 1'b1;
        lsu_runs = 0;
      end
      if (lsu_valid && lsu_ready) begin
        if (!hits_timer(lsu_req.addr)) begin
          lsu_kind = 0;
        end else begin
          lsu_kind = (lsu_req.addr == RTC_ADDR_HI) ? 2 : 1;
        end
        lsu_exp  = model_word(lsu_req.addr);
        lsu_wait = 1'b1;
        ifu_runs = 0;
      end
      if (st_valid && st_ready) begin
        model_store(st_req);
        st_wait = 1'b1;
      end

      // next requests
      if (ifu_valid && ifu_ready) begin
        ifu_valid <= 1'b0;
      end else if (!ifu_valid && !ifu_wait && ifu_sent < N_FETCH) begin
        r = next_rand();
        a = pick_read_addr(r[31:8]);
        // hold off while a store to the same word is waiting
        if (r[1:0] != 2'b00 && !(st_valid && st_req.addr == a)) begin
          ifu_req.addr <= a;
          ifu_valid    <= 1'b1;
          ifu_sent++;
        end
      end
      if (lsu_valid && lsu_ready) begin
        lsu_valid <= 1'b0;
      end else if (!lsu_valid && !lsu_wait && lsu_sent < N_LOAD) begin
        r = next_rand();
        a = pick_read_addr(r[31:8]);
        if (r[1:0] != 2'b00 && !(st_valid && st_req.addr == a)) begin
          lsu_req.addr <= a;
          lsu_valid    <= 1'b1;
          lsu_sent++;
        end
      end
      if (st_valid && st_ready) begin
        st_valid <= 1'b0;
      end else if (!st_valid && !st_wait && st_sent < N_STORE) begin
        r = next_rand();
        if (r[0]) begin
          st_req.addr <= (r[3:2] == 2'b00) ? SERIAL_ADDR : addr_t'({r[7:4], 2'b00});
          st_req.data <= next_rand();
          st_req.strb <= r[11:8];
          st_valid    <= 1'b1;
          st_sent++;
        end
      end
      // random back-pressure on all responses
      r = next_rand();
      ifu_rsp_rdy <= r[0];
      lsu_rsp_rdy <= r[1];
      st_rsp_rdy  <= r[2];
    end
  end

  initial begin
    int total_checks;
    int total_errs;
    rst         = 1'b1;
    ifu_req     = '0;
    ifu_valid   = 1'b0;
    ifu_rsp_rdy = 1'b0;
    lsu_req     = '0;
    lsu_valid   = 1'b0;
    lsu_rsp_rdy = 1'b0;
    st_req      = '0;
    st_valid    = 1'b0;
    st_rsp_rdy  = 1'b0;
    rng_state   = 32'h86bbfa15;
    model_clear();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value(4, {ifu_rsp_valid, lsu_rsp_valid, st_rsp_valid, uart_char_valid}, 0,
                "valid outputs after reset");
    while (!all_done() && cycles < MAX_CYCLES) begin
      @(negedge clk);
    end
    if (!all_done()) begin
      $display("timeout: %0d cycles passed and transfers are still open", cycles);
      $display("Verification failed");
    end else begin
      // late or duplicated serial bytes would show up here
      repeat (2 * UART_DIV) @(negedge clk);
      total_checks = 0;
      total_errs   = 0;
      for (int i = 0; i < 5; i++) begin
        $display("test %s: %0d checks, %0d errors", test_name[i], checks[i], errs[i]);
        total_checks += checks[i];
        total_errs   += errs[i];
      end
      $display("total: %0d checks, %0d errors", total_checks, total_errs);
      if (total_errs == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/soc_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top import soc_bus_pkg::*; (
  input  wire     clk,
  input  wire     rst,
  input  rd_req_t ifu_rd_req_i,
  input  wire     ifu_rd_valid_i,
  output logic    ifu_rd_ready_o,
  output rd_rsp_t ifu_rd_rsp_o,
  output logic    ifu_rsp_valid_o,
  input  wire     ifu_rsp_ready_i,
  input  rd_req_t lsu_rd_req_i,
  input  wire     lsu_rd_valid_i,
  output logic    lsu_rd_ready_o,
  output rd_rsp_t lsu_rd_rsp_o,
  output logic    lsu_rsp_valid_o,
  input  wire     lsu_rsp_ready_i,
  input  wr_req_t lsu_wr_req_i,
  input  wire     lsu_wr_valid_i,
  output logic    lsu_wr_ready_o,
  output wr_rsp_t lsu_wr_rsp_o,
  output logic    lsu_wr_rsp_valid_o,
  input  wire     lsu_wr_rsp_ready_i,
  output byte_t   uart_char_o,
  output logic    uart_char_valid_o
);

  rd_req_t mem_rd_req;
  rd_req_t clint_rd_req;
  rd_rsp_t mem_rd_rsp;
  rd_rsp_t clint_rd_rsp;
  wr_req_t mem_wr_req;
  wr_req_t uart_wr_req;
  wr_rsp_t mem_wr_rsp;
  wr_rsp_t uart_wr_rsp;
  logic mem_rd_valid, mem_rd_ready, mem_rd_rsp_valid, mem_rd_rsp_ready;
  logic mem_wr_valid, mem_wr_ready, mem_wr_rsp_valid, mem_wr_rsp_ready;
  logic clint_rd_valid, clint_rd_ready, clint_rd_rsp_valid, clint_rd_rsp_ready;
  logic uart_wr_valid, uart_wr_ready, uart_wr_rsp_valid, uart_wr_rsp_ready;

  bus_arbiter u_arbiter (
    .clk                  (clk),
    .rst                  (rst),
    .ifu_rd_req_i         (ifu_rd_req_i),
    .ifu_rd_valid_i       (ifu_rd_valid_i),
    .ifu_rd_ready_o       (ifu_rd_ready_o),
    .ifu_rd_rsp_o         (ifu_rd_rsp_o),
    .ifu_rsp_valid_o      (ifu_rsp_valid_o),
    .ifu_rsp_ready_i      (ifu_rsp_ready_i),
    .lsu_rd_req_i         (lsu_rd_req_i),
    .lsu_rd_valid_i       (lsu_rd_valid_i),
    .lsu_rd_ready_o       (lsu_rd_ready_o),
    .lsu_rd_rsp_o         (lsu_rd_rsp_o),
    .lsu_rsp_valid_o      (lsu_rsp_valid_o),
    .lsu_rsp_ready_i      (lsu_rsp_ready_i),
    .lsu_wr_req_i         (lsu_wr_req_i),
    .lsu_wr_valid_i       (lsu_wr_valid_i),
    .lsu_wr_ready_o       (lsu_wr_ready_o),
    .lsu_wr_rsp_o         (lsu_wr_rsp_o),
    .lsu_wr_rsp_valid_o   (lsu_wr_rsp_valid_o),
    .lsu_wr_rsp_ready_i   (lsu_wr_rsp_ready_i),
    .mem_rd_req_o         (mem_rd_req),
    .mem_rd_valid_o       (mem_rd_valid),
    .mem_rd_ready_i       (mem_rd_ready),
    .mem_rd_rsp_i         (mem_rd_rsp),
    .mem_rd_rsp_valid_i   (mem_rd_rsp_valid),
    .mem_rd_rsp_ready_o   (mem_rd_rsp_ready),
    .mem_wr_req_o         (mem_wr_req),
    .mem_wr_valid_o       (mem_wr_valid),
    .mem_wr_ready_i       (mem_wr_ready),
    .mem_wr_rsp_i         (mem_wr_rsp),
    .mem_wr_rsp_valid_i   (mem_wr_rsp_valid),
    .mem_wr_rsp_ready_o   (mem_wr_rsp_ready),
    .clint_rd_req_o       (clint_rd_req),
    .clint_rd_valid_o     (clint_rd_valid),
    .clint_rd_ready_i     (clint_rd_ready),
    .clint_rd_rsp_i       (clint_rd_rsp),
    .clint_rd_rsp_valid_i (clint_rd_rsp_valid),
    .clint_rd_rsp_ready_o (clint_rd_rsp_ready),
    .uart_wr_req_o        (uart_wr_req),
    .uart_wr_valid_o      (uart_wr_valid),
    .uart_wr_ready_i      (uart_wr_ready),
    .uart_wr_rsp_i        (uart_wr_rsp),
    .uart_wr_rsp_valid_i  (uart_wr_rsp_valid),
    .uart_wr_rsp_ready_o  (uart_wr_rsp_ready)
  );

  sram_slave u_sram (
    .clk            (clk),
    .rst            (rst),
    .rd_req_i       (mem_rd_req),
    .rd_valid_i     (mem_rd_valid),
    .rd_ready_o     (mem_rd_ready),
    .rd_rsp_o       (mem_rd_rsp),
    .rd_rsp_valid_o (mem_rd_rsp_valid),
    .rd_rsp_ready_i (mem_rd_rsp_ready),
    .wr_req_i       (mem_wr_req),
    .wr_valid_i     (mem_wr_valid),
    .wr_ready_o     (mem_wr_ready),
    .wr_rsp_o       (mem_wr_rsp),
    .wr_rsp_valid_o (mem_wr_rsp_valid),
    .wr_rsp_ready_i (mem_wr_rsp_ready)
  );

  clint_timer u_clint (
    .clk            (clk),
    .rst            (rst),
    .rd_req_i       (clint_rd_req),
    .rd_valid_i     (clint_rd_valid),
    .rd_ready_o     (clint_rd_ready),
    .rd_rsp_o       (clint_rd_rsp),
    .rd_rsp_valid_o (clint_rd_rsp_valid),
    .rd_rsp_ready_i (clint_rd_rsp_ready)
  );

  uart_tx_queue u_uart (
    .clk            (clk),
    .rst            (rst),
    .wr_req_i       (uart_wr_req),
    .wr_valid_i     (uart_wr_valid),
    .wr_ready_o     (uart_wr_ready),
    .wr_rsp_o       (uart_wr_rsp),
    .wr_rsp_valid_o (uart_wr_rsp_valid),
    .wr_rsp_ready_i (uart_wr_rsp_ready),
    .char_o         (uart_char_o),
    .char_valid_o   (uart_char_valid_o)
  );

endmodule

`default_nettype wire

// ==== verilog/sram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_slave import soc_bus_pkg::*; (
  input  wire     clk,
  input  wire     rst,
  input  rd_req_t rd_req_i,
  input  wire     rd_valid_i,
  output logic    rd_ready_o,
  output rd_rsp_t rd_rsp_o,
  output logic    rd_rsp_valid_o,
  input  wire     rd_rsp_ready_i,
  input  wr_req_t wr_req_i,
  input  wire     wr_valid_i,
  output logic    wr_ready_o,
  output wr_rsp_t wr_rsp_o,
  output logic    wr_rsp_valid_o,
  input  wire     wr_rsp_ready_i
);

  data_t    mem_q [MEM_WORDS];
  lfsr_t    lfsr_q;
  data_t    rd_data_q;
  logic     rd_valid_q;
  logic     wr_valid_q;
  mem_idx_t rd_idx;
  mem_idx_t wr_idx;
  logic     gate;
  logic     rd_acc;
  logic     wr_acc;

  assign rd_idx = rd_req_i.addr[MEM_AW+1:2];
  assign wr_idx = wr_req_i.addr[MEM_AW+1:2];

  // x^20 + x^17 + 1, top bit throttles both channels
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr_q <= lfsr_t'(1);
    end else begin
      lfsr_q <= {lfsr_q[LFSR_W-2:0], lfsr_q[19] ^ lfsr_q[16]};
    end
  end

  assign gate       = lfsr_q[LFSR_W-1];
  assign rd_ready_o = gate && !rd_valid_q;
  assign wr_ready_o = gate && !wr_valid_q;
  assign rd_acc     = rd_valid_i && rd_ready_o;
  assign wr_acc     = wr_valid_i && wr_ready_o;

  // word array, cleared in reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_acc) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_req_i.strb[b]) begin
          mem_q[wr_idx][8*b +: 8] <= wr_req_i.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_acc) begin
      rd_data_q <= mem_q[rd_idx];
    end
  end

  // one-entry response registers, held until taken
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid_q <= 1'b0;
      wr_valid_q <= 1'b0;
    end else begin
      if (rd_acc) begin
        rd_valid_q <= 1'b1;
      end else if (rd_rsp_ready_i) begin
        rd_valid_q <= 1'b0;
      end
      if (wr_acc) begin
        wr_valid_q <= 1'b1;
      end else if (wr_rsp_ready_i) begin
        wr_valid_q <= 1'b0;
      end
    end
  end

  assign rd_rsp_o.data  = rd_data_q;
  assign rd_rsp_o.resp  = OKAY;
  assign rd_rsp_valid_o = rd_valid_q;
  assign wr_rsp_o.resp  = OKAY;
  assign wr_rsp_valid_o = wr_valid_q;

endmodule

`default_nettype wire
